/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = div_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+hdl
hdl/div_data_pkg.sv
hdl/div_flow_pkg.sv
hdl/div_operand_prep.sv
hdl/div_step_cell.sv
hdl/div_result_fix.sv
hdl/div_out_buffer.sv
hdl/div_pipe_top.sv
tb/div_clk_gen.sv
tb/div_tb.sv

/* hdl/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand width
`define DIV_XLEN 32

// request tag width
`define DIV_TAG_W 4

// output FIFO entries, also the initial credit count on both sides
`define DIV_BUF_DEPTH 8

// must hold DIV_BUF_DEPTH
`define DIV_CREDIT_W 4

`endif

/* hdl/div_data_pkg.sv */
`default_nettype none
`include "div_config.svh"

package div_data_pkg;

    typedef logic [`DIV_XLEN-1:0]  operand_t;
    typedef logic [`DIV_TAG_W-1:0] tag_t;

    typedef struct packed {
        operand_t dividend;
        operand_t divisor;
        logic     is_signed;    // 0 for unsigned
        logic     want_rem;     // 0 for quotient
        tag_t     tag;
    } div_req_t;

    typedef struct packed {
        operand_t rem;            // partial remainder
        operand_t quot;           // dividend bits out, quotient bits in
        operand_t divisor;        // absolute value
        logic     negate_quot;
        logic     negate_rem;
        logic     div_zero;
        logic     overflow;       // most negative / -1
        operand_t orig_dividend;
        logic     want_rem;
        tag_t     tag;
        logic     valid;
    } div_stage_t;

    typedef struct packed {
        operand_t value;
        tag_t     tag;
    } div_res_t;

endpackage

`default_nettype wire

/* hdl/div_flow_pkg.sv */
`default_nettype none
`include "div_config.svh"

package div_flow_pkg;

    // holds 0 .. DIV_BUF_DEPTH
    typedef logic [`DIV_CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

/* hdl/div_operand_prep.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_operand_prep (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid,
    input  div_data_pkg::div_req_t   req,
    output div_data_pkg::div_stage_t stage_out
);

    div_data_pkg::div_stage_t stage_d;
    div_data_pkg::div_stage_t stage_q;
    logic                     valid_q;
    logic                     a_neg;
    logic                     b_neg;

    always_comb begin
        a_neg = req.is_signed & req.dividend[`DIV_XLEN-1];
        b_neg = req.is_signed & req.divisor[`DIV_XLEN-1];

        stage_d               = '0;
        stage_d.quot          = a_neg ? -req.dividend : req.dividend;
        stage_d.divisor       = b_neg ? -req.divisor : req.divisor;
        stage_d.negate_quot   = a_neg ^ b_neg;  // signs differ
        stage_d.negate_rem    = a_neg;          // remainder follows dividend
        stage_d.div_zero      = (req.divisor == '0);
        stage_d.overflow      = req.is_signed
                                && (req.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}})
                                && (&req.divisor);
        stage_d.orig_dividend = req.dividend;
        stage_d.want_rem      = req.want_rem;
        stage_d.tag           = req.tag;
        stage_d.valid         = req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            stage_q <= stage_d;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    always_comb begin
        stage_out       = stage_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

/* hdl/div_out_buffer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_out_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_valid,
    input  div_data_pkg::div_res_t wr_res,
    input  logic                   out_credit,
    output logic                   res_valid,
    output div_data_pkg::div_res_t res,
    output logic                   in_credit
);

    localparam int PTR_W = $clog2(`DIV_BUF_DEPTH);

    div_data_pkg::div_res_t mem [`DIV_BUF_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    div_flow_pkg::credit_t  credits;    // downstream credits held
    logic                   pop;

    assign pop = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_res;
        end
        if (pop) begin
            res <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= div_flow_pkg::credit_t'(`DIV_BUF_DEPTH);
            res_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`DIV_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`DIV_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // returned and spent together
            endcase
            res_valid <= pop;
            in_credit <= pop;   // slot freed, source may send again
        end
    end

endmodule

`default_nettype wire

/* hdl/div_pipe_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_pipe_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  div_data_pkg::div_req_t req,
    output logic                   in_credit,
    output logic                   res_valid,
    output div_data_pkg::div_res_t res,
    input  logic                   out_credit
);

    div_data_pkg::div_stage_t stage_chain [`DIV_XLEN+1];  // prep out .. last step out
    logic                     fix_valid;
    div_data_pkg::div_res_t   fix_res;

    div_operand_prep u_prep (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .stage_out (stage_chain[0])
    );

    // one quotient bit per stage, msb first
    for (genvar i = 0; i < `DIV_XLEN; i++) begin : g_step
        div_step_cell u_step (
            .clk       (clk),
            .rstn      (rstn),
            .stage_in  (stage_chain[i]),
            .stage_out (stage_chain[i+1])
        );
    end

    div_result_fix u_fix (
        .clk       (clk),
        .rstn      (rstn),
        .stage_in  (stage_chain[`DIV_XLEN]),
        .res_valid (fix_valid),
        .res       (fix_res)
    );

    div_out_buffer u_buf (
        .clk        (clk),
        .rstn       (rstn),
        .wr_valid   (fix_valid),
        .wr_res     (fix_res),
        .out_credit (out_credit),
        .res_valid  (res_valid),
        .res        (res),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

/* hdl/div_result_fix.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_result_fix (
    input  logic                     clk,
    input  logic                     rstn,
    input  div_data_pkg::div_stage_t stage_in,
    output logic                     res_valid,
    output div_data_pkg::div_res_t   res
);

    div_data_pkg::operand_t quot;
    div_data_pkg::operand_t rem;
    div_data_pkg::div_res_t res_d;

    always_comb begin
        quot = stage_in.negate_quot ? -stage_in.quot : stage_in.quot;
        rem  = stage_in.negate_rem ? -stage_in.rem : stage_in.rem;

        if (stage_in.div_zero) begin
            quot = '1;
            rem  = stage_in.orig_dividend;
        end else if (stage_in.overflow) begin
            quot = stage_in.orig_dividend;  // wraps back to itself
            rem  = '0;
        end

        res_d.value = stage_in.want_rem ? rem : quot;
        res_d.tag   = stage_in.tag;
    end

    always_ff @(posedge clk) begin
        if (stage_in.valid) begin
            res <= res_d;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= stage_in.valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/div_step_cell.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_step_cell (
    input  logic                     clk,
    input  logic                     rstn,
    input  div_data_pkg::div_stage_t stage_in,
    output div_data_pkg::div_stage_t stage_out
);

    div_data_pkg::div_stage_t stage_d;
    div_data_pkg::div_stage_t stage_q;
    logic                     valid_q;
    logic [`DIV_XLEN:0]       shifted;
    logic [`DIV_XLEN:0]       diff;
    logic                     q_bit;

    always_comb begin
        shifted = {stage_in.rem, stage_in.quot[`DIV_XLEN-1]};  // bring down next bit
        diff    = shifted - {1'b0, stage_in.divisor};
        q_bit   = ~diff[`DIV_XLEN];                          // no borrow

        stage_d      = stage_in;
        stage_d.rem  = q_bit ? diff[`DIV_XLEN-1:0] : shifted[`DIV_XLEN-1:0];
        stage_d.quot = {stage_in.quot[`DIV_XLEN-2:0], q_bit};
    end

    always_ff @(posedge clk) begin
        if (stage_in.valid) begin
            stage_q <= stage_d;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    always_comb begin
        stage_out       = stage_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

/* tb/div_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module div_clk_gen (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD  = 20;  // 40 ns period
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;  // released on a falling edge
    end

endmodule

`default_nettype wire

/* tb/div_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "div_config.svh"

module div_tb;

    localparam int LATENCY    = 35;
    localparam int WAIT_LIMIT = 2000;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid = 1'b0;
    div_data_pkg::div_req_t req = '0;
    logic                   in_credit;
    logic                   res_valid;
    div_data_pkg::div_res_t res;
    logic                   out_credit = 1'b0;

    div_data_pkg::div_req_t send_q [$];     // waiting for an input credit
    div_data_pkg::div_res_t expect_q [$];
    int                     sent_at_q [$];
    div_flow_pkg::credit_t  src_credits = div_flow_pkg::credit_t'(`DIV_BUF_DEPTH);
    div_flow_pkg::credit_t  owed = '0;      // downstream credits not yet returned
    logic                   hold_credits = 1'b0;
    div_data_pkg::tag_t     next_tag = '0;
    int                     cycle = 0;
    int                     sent = 0;
    int                     received = 0;
    int                     credits_back = 0;
    int                     last_latency = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     timeouts = 0;

    div_clk_gen u_clk (
        .clk  (clk),
        .rstn (rstn)
    );

    div_pipe_top dut (.*);

    // RISC-V M rules, division by zero and signed overflow first
    function automatic div_data_pkg::div_res_t expected_result(div_data_pkg::div_req_t r);
        div_data_pkg::operand_t quot;
        div_data_pkg::operand_t rem;
        div_data_pkg::div_res_t e;
        if (r.divisor == '0) begin
            quot = '1;
            rem  = r.dividend;
        end else if (r.is_signed && r.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}}
                     && r.divisor == '1) begin
            quot = r.dividend;
            rem  = '0;
        end else if (r.is_signed) begin
            quot = $signed(r.dividend) / $signed(r.divisor);  // truncates toward zero
            rem  = $signed(r.dividend) % $signed(r.divisor);
        end else begin
            quot = r.dividend / r.divisor;
            rem  = r.dividend % r.divisor;
        end
        e.value = r.want_rem ? rem : quot;
        e.tag   = r.tag;
        return e;
    endfunction

    // source, sink and scoreboard
    always @(negedge clk) begin
        div_data_pkg::div_res_t exp_res;
        cycle      = cycle + 1;
        req_valid  = 1'b0;
        out_credit = 1'b0;
        if (rstn) begin
            checks = checks + 1;
            assert (in_credit == res_valid) else begin
                errors = errors + 1;
                $display("Error: in_credit %h with res_valid %h", in_credit, res_valid);
            end
            if (in_credit) begin
                src_credits  = src_credits + 1'b1;
                credits_back = credits_back + 1;
            end
            if (res_valid) begin
                received = received + 1;
                owed     = owed + 1'b1;
                checks   = checks + 1;
                assert (expect_q.size() != 0) else begin
                    errors = errors + 1;
                    $display("Result with tag %h arrived with no request outstanding", res.tag);
                end
                if (expect_q.size() != 0) begin
                    exp_res      = expect_q.pop_front();
                    last_latency = cycle - sent_at_q.pop_front() - 1;
                    checks       = checks + 1;
                    assert (res == exp_res) else begin
                        errors = errors + 1;
                        $display("Error: res tag %h value %h, expected tag %h value %h",
                                 res.tag, res.value, exp_res.tag, exp_res.value);
                    end
                end
            end
            if (!hold_credits && owed != '0) begin
                out_credit = 1'b1;
                owed       = owed - 1'b1;
            end
            if (send_q.size() != 0 && src_credits != '0) begin
                req         = send_q.pop_front();
                req_valid   = 1'b1;
                src_credits = src_credits - 1'b1;
                sent        = sent + 1;
                expect_q.push_back(expected_result(req));
                sent_at_q.push_back(cycle);
            end
        end
    end

    task automatic queue_request(input div_data_pkg::operand_t a, input div_data_pkg::operand_t b,
                                 input logic is_signed, input logic want_rem);
        div_data_pkg::div_req_t r;
        r.dividend  = a;
        r.divisor   = b;
        r.is_signed = is_signed;
        r.want_rem  = want_rem;
        r.tag       = next_tag;
        next_tag    = next_tag + 1'b1;
        send_q.push_back(r);
    endtask

    // unsigned and signed, quotient and remainder
    task automatic queue_all_modes(input div_data_pkg::operand_t a,
                                   input div_data_pkg::operand_t b);
        queue_request(a, b, 1'b0, 1'b0);
        queue_request(a, b, 1'b0, 1'b1);
        queue_request(a, b, 1'b1, 1'b0);
        queue_request(a, b, 1'b1, 1'b1);
    endtask

    task automatic wait_results(input int target, input string what);
        int waited;
        waited = 0;
        while (received < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (received < target) begin
            timeouts = timeouts + 1;
            $display("Timeout in %s: %0d of %0d results arrived", what, received, target);
        end
    endtask

    task automatic check_idle_after_reset();
        int waited;
        waited = 0;
        while (!rstn && waited < 100) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (!rstn) begin
            timeouts = timeouts + 1;
            $display("Timeout: reset was never released");
        end
        repeat (8) begin
            @(negedge clk);
            checks = checks + 1;
            assert (!res_valid && !in_credit) else begin
                errors = errors + 1;
                $display("Error: res_valid %h in_credit %h while idle", res_valid, in_credit);
            end
        end
        @(posedge clk);
    endtask

    task automatic check_single_latency();
        queue_request(32'd1000, 32'd7, 1'b0, 1'b0);
        wait_results(received + 1, "single request");
        checks = checks + 1;
        assert (last_latency == LATENCY) else begin
            errors = errors + 1;
            $display("Error: res_valid latency %h, expected %h", last_latency, LATENCY);
        end
    endtask

    task automatic check_special_cases();
        queue_all_modes(32'h1234_5678, '0);
        queue_all_modes(32'h8765_4321, '0);
        queue_all_modes('0, '0);
        queue_all_modes(32'h8000_0000, '1);  // overflow in signed mode only
        wait_results(received + 16, "special cases");
    endtask

    task automatic check_operands();
        div_data_pkg::operand_t dvd [8] = '{32'd100, -32'd100, 32'd100, -32'd100,
                                             32'd7, 32'hffff_ffff, 32'h8000_0000, 32'd123456789};
        div_data_pkg::operand_t dvs [8] = '{32'd7, 32'd7, -32'd7, -32'd7,
                                             32'd100, 32'd1, 32'd2, -32'd1000};
        int base;
        base = received;
        for (int i = 0; i < 8; i++) begin
            queue_all_modes(dvd[i], dvs[i]);
        end
        for (int i = 0; i < 24; i++) begin
            queue_all_modes($urandom(), $urandom() >> ($urandom() % 32));  // mixed divisor sizes
        end
        wait_results(base + 128, "directed and random operands");
    endtask

    task automatic check_backpressure();
        int base_rcv;
        int base_sent;
        int base_back;
        int waited;
        base_rcv     = received;
        base_sent    = sent;
        hold_credits = 1'b1;
        for (int i = 0; i < 2 * `DIV_BUF_DEPTH; i++) begin
            queue_request($urandom(), 32'd3 + i, 1'b1, i[0]);
        end
        wait_results(base_rcv + `DIV_BUF_DEPTH, "back-pressure first batch");
        waited = 0;
        while (sent < base_sent + 2 * `DIV_BUF_DEPTH && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (sent < base_sent + 2 * `DIV_BUF_DEPTH) begin
            timeouts = timeouts + 1;
            $display("Timeout: second batch was never sent");
        end
        base_rcv  = received;
        base_back = credits_back;
        repeat (3 * LATENCY) @(posedge clk);  // buffer fills in this window
        checks = checks + 1;
        assert (received == base_rcv && credits_back == base_back) else begin
            errors = errors + 1;
            $display("Results or input credits kept flowing without downstream credit");
        end
        hold_credits = 1'b0;
        wait_results(base_rcv + `DIV_BUF_DEPTH, "back-pressure release");
    endtask

    initial begin
        int unsigned seed;
        seed = $urandom(32'h288eb78c);
        check_idle_after_reset();
        check_single_latency();
        check_special_cases();
        check_operands();
        check_backpressure();
        checks = checks + 1;
        assert (expect_q.size() == 0 && send_q.size() == 0) else begin
            errors = errors + 1;
            $display("%0d requests never produced a result", expect_q.size() + send_q.size());
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
